// File: sources.f
source/pixel_pkg.sv
source/raster_pkg.sv
source/raster_counter.sv
source/line_buffer.sv
source/window_sum.sv
source/box_filter_top.sv
verification/box_filter_checker.sv
verification/box_filter_tb.sv

// File: Bender.yml
package:
  name: box_filter

sources:
  - files:
      - source/pixel_pkg.sv
      - source/raster_pkg.sv
      - source/raster_counter.sv
      - source/line_buffer.sv
      - source/window_sum.sv
      - source/box_filter_top.sv
  - target: test
    files:
      - verification/box_filter_checker.sv
      - verification/box_filter_tb.sv

// File: verification/box_filter_tb.sv
`timescale 1ns/100ps

module box_filter_tb;
    import pixel_pkg::*;
    import raster_pkg::*;

    localparam int COLS     = 16;
    localparam int ROWS     = 8;
    localparam int FRAME    = COLS * ROWS;
    localparam int PARTIAL  = 70;  // Pixels before the mid-frame reset
    localparam int MAX_GAP  = 3;
    localparam int N_PIXELS = 5 * FRAME + PARTIAL;
    localparam int TIMEOUT  = N_PIXELS * (MAX_GAP + 1) + 200;

    logic        clk;
    logic        rst;
    logic        in_valid;
    pixel_t      in_pixel;
    logic        flat;
    logic        out_valid;
    winsum_t     out_sum;
    raster_pos_t out_pos;
    int          mismatches;
    int          failures;
    int          pending;
    logic [31:0] lfsr;

    box_filter_top #(.COLS(COLS), .ROWS(ROWS)) uut (
        .clk     (clk),
        .rst     (rst),
        .i_valid (in_valid),
        .i_pixel (in_pixel),
        .o_valid (out_valid),
        .o_sum   (out_sum),
        .o_pos   (out_pos)
    );

    box_filter_checker #(.COLS(COLS), .ROWS(ROWS)) u_checker (
        .clk          (clk),
        .rst          (rst),
        .i_flat       (flat),
        .i_in_valid   (in_valid),
        .i_in_pixel   (in_pixel),
        .i_out_valid  (out_valid),
        .i_out_sum    (out_sum),
        .i_out_pos    (out_pos),
        .o_mismatches (mismatches),
        .o_failures   (failures),
        .o_pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ####################
    // Stimulus helpers
    // ####################

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic send_pixel(input pixel_t pix, input int gap);
        @(negedge clk);
        in_valid = 1'b1;
        in_pixel = pix;
        for (int k = 0; k < gap; k++) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_random(input int count, input bit with_gaps);
        logic [31:0] pix;
        logic [31:0] gap;
        for (int n = 0; n < count; n++) begin
            draw_bits(PIX_W, pix);
            gap = '0;
            if (with_gaps) begin
                draw_bits(2, gap);
            end
            send_pixel(pixel_t'(pix), int'(gap));
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        in_valid = 1'b0;  // Pixels still in the pipeline get dropped
        rst      = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    // ####################
    // Test sequence
    // ####################

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_pixel = '0;
        flat     = 1'b0;
        lfsr     = 32'h7e92;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (10) @(negedge clk);  // Output must stay quiet while idle

        send_random(2 * FRAME, 1'b0);  // Two frames back to back
        send_random(FRAME, 1'b1);
        go_idle();
        flat = 1'b1;
        for (int n = 0; n < FRAME; n++) begin
            send_pixel(8'hff, 0);
        end
        go_idle();
        flat = 1'b0;
        send_random(PARTIAL, 1'b0);
        apply_reset();
        send_random(FRAME, 1'b0);
        go_idle();

        wait (pending == 0);
        repeat (10) @(posedge clk);
        $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
        $display("tests failed");
        $finish;
    end

endmodule

// File: verification/box_filter_checker.sv
`timescale 1ns/100ps

module box_filter_checker #(
    parameter int COLS = 16,
    parameter int ROWS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_flat,      // Current frame is all 255
    input  logic                    i_in_valid,
    input  pixel_pkg::pixel_t       i_in_pixel,
    input  logic                    i_out_valid,
    input  pixel_pkg::winsum_t      i_out_sum,
    input  raster_pkg::raster_pos_t i_out_pos,
    output int                      o_mismatches,
    output int                      o_failures,
    output int                      o_pending
);
    import pixel_pkg::*;
    import raster_pkg::*;

    localparam int LATENCY = 5;

    typedef struct packed {
        int          due;  // Cycle in which the result must show up
        winsum_t     sum;
        raster_pos_t pos;
    } expect_t;

    int      image [ROWS][COLS];
    int      row = 0;
    int      col = 0;
    int      cycle = 0;
    int      mismatches = 0;
    int      failures = 0;
    logic    rst_seen = 1'b0;  // Reset was high on the previous edge
    expect_t queue [$];

    assign o_mismatches = mismatches;
    assign o_failures   = failures;

    // Plain 5x5 sum with zeros above and left of the frame
    function automatic int window_total(input int r, input int c);
        int total;
        total = 0;
        for (int dr = 0; dr < 5; dr++) begin
            for (int dc = 0; dc < 5; dc++) begin
                if (r - dr >= 0 && c - dc >= 0) begin
                    total += image[r-dr][c-dc];
                end
            end
        end
        return total;
    endfunction

    function automatic int flat_total(input int r, input int c);
        return 255 * ((r < 4 ? r : 4) + 1) * ((c < 4 ? c : 4) + 1);
    endfunction

    always @(posedge clk) begin : check
        expect_t item;
        logic    due_now;
        cycle++;
        if (rst) begin
            // One edge into reset the output must already be quiet
            if (rst_seen && i_out_valid !== 1'b0) begin
                failures++;
                $display("%0t: o_valid is still high while reset is held", $time);
            end
            rst_seen = 1'b1;
            queue.delete();  // In-flight pixels are lost
            row = 0;
            col = 0;
        end else begin
            rst_seen = 1'b0;
            // ####################
            // Output side
            // ####################
            due_now = (queue.size() > 0) && (queue[0].due == cycle);
            if (i_out_valid !== due_now) begin
                failures++;
                if (due_now) begin
                    $display("%0t: result for row %0d col %0d did not arrive on time",
                             $time, queue[0].pos.row, queue[0].pos.col);
                end else begin
                    $display("%0t: o_valid is %b with no result due", $time, i_out_valid);
                end
            end else if (due_now) begin
                if (i_out_sum !== queue[0].sum) begin
                    mismatches++;
                    $display("MISMATCH %0t o_sum expected %0d actual %0d",
                             $time, queue[0].sum, i_out_sum);
                end
                if (i_out_pos !== queue[0].pos) begin
                    mismatches++;
                    $display("MISMATCH %0t o_pos expected (%0d,%0d) actual (%0d,%0d)",
                             $time, queue[0].pos.row, queue[0].pos.col,
                             i_out_pos.row, i_out_pos.col);
                end
            end
            if (due_now) begin
                void'(queue.pop_front());
            end

            // ####################
            // Input side
            // ####################
            if (i_in_valid === 1'b1) begin
                image[row][col] = i_in_pixel;
                item.due     = cycle + LATENCY;
                item.sum     = i_flat ? winsum_t'(flat_total(row, col))
                                      : winsum_t'(window_total(row, col));
                item.pos.row = POS_W'(row);
                item.pos.col = POS_W'(col);
                queue.push_back(item);
                col++;
                if (col == COLS) begin  // Raster wrap
                    col = 0;
                    row = (row == ROWS - 1) ? 0 : row + 1;
                end
            end
        end
        o_pending = queue.size();
    end

endmodule

// File: source/box_filter_top.sv
`timescale 1ns/100ps

module box_filter_top #(
    parameter int COLS = 16,
    parameter int ROWS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  pixel_pkg::pixel_t       i_pixel,
    output logic                    o_valid,
    output pixel_pkg::winsum_t      o_sum,
    output raster_pkg::raster_pos_t o_pos
);
    import pixel_pkg::*;
    import raster_pkg::*;

    raster_pos_t pos_in;     // Position of the incoming pixel
    logic        col_valid;
    column_t     col_data;   // Five-pixel column, one cycle later
    raster_pos_t col_pos;

    // ####################
    // Pixel position
    // ####################

    raster_counter #(
        .COLS (COLS),
        .ROWS (ROWS)
    ) u_raster_counter (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .o_pos   (pos_in)
    );

    // ####################
    // Column builder
    // ####################

    line_buffer #(
        .COLS (COLS)
    ) u_line_buffer (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_pixel  (i_pixel),
        .i_pos    (pos_in),
        .o_valid  (col_valid),
        .o_column (col_data),
        .o_pos    (col_pos)
    );

    // ####################
    // Window summer
    // ####################

    window_sum #(
        .COLS (COLS)
    ) u_window_sum (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (col_valid),
        .i_column (col_data),
        .i_pos    (col_pos),
        .o_valid  (o_valid),
        .o_sum    (o_sum),
        .o_pos    (o_pos)
    );

endmodule

// File: source/window_sum.sv
`timescale 1ns/100ps

module window_sum #(
    parameter int COLS = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  pixel_pkg::column_t      i_column,
    input  raster_pkg::raster_pos_t i_pos,
    output logic                    o_valid,
    output pixel_pkg::winsum_t      o_sum,
    output raster_pkg::raster_pos_t o_pos
);
    import pixel_pkg::*;
    import raster_pkg::*;

    localparam int PAIR_W = PIX_W + 1;
    localparam int QUAD_W = PIX_W + 2;
    localparam int COL_W  = $clog2(COLS);  // Columns never exceed COLS-1

    // Payload of the first adder stage
    typedef struct packed {
        raster_pos_t       pos;
        logic [PAIR_W-1:0] pair_hi;  // top + up3
        logic [PAIR_W-1:0] pair_lo;  // up2 + up1
        pixel_t            cur;
    } stage1_t;

    // Payload of the second adder stage
    typedef struct packed {
        raster_pos_t       pos;
        logic [QUAD_W-1:0] quad;
        pixel_t            cur;
    } stage2_t;

    // Payload of the column sum stage
    typedef struct packed {
        raster_pos_t pos;
        colsum_t     sum;
    } stage3_t;

    logic    s1_valid;
    logic    s2_valid;
    logic    s3_valid;
    stage1_t s1;
    stage2_t s2;
    stage3_t s3;

    colsum_t           hist [WIN];  // hist[k] is the column sum k+1 columns back
    winsum_t           acc_q;
    winsum_t           acc_next;
    logic [COL_W-1:0]  s3_col;

    // ####################
    // Valid pipeline
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            o_valid  <= s3_valid;
        end
    end

    // ####################
    // Column adder tree
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            s1 <= '0;
            s2 <= '0;
            s3 <= '0;
        end else begin
            if (i_valid) begin
                s1.pos     <= i_pos;
                s1.pair_hi <= PAIR_W'(i_column.top) + PAIR_W'(i_column.up3);
                s1.pair_lo <= PAIR_W'(i_column.up2) + PAIR_W'(i_column.up1);
                s1.cur     <= i_column.cur;  // Fifth pixel waits a stage
            end
            if (s1_valid) begin
                s2.pos  <= s1.pos;
                s2.quad <= QUAD_W'(s1.pair_hi) + QUAD_W'(s1.pair_lo);
                s2.cur  <= s1.cur;
            end
            if (s2_valid) begin
                s3.pos <= s2.pos;
                s3.sum <= colsum_t'(s2.quad) + colsum_t'(s2.cur);
            end
        end
    end

    // ####################
    // Column sum history
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < WIN; k++) begin
                hist[k] <= '0;
            end
        end else if (s3_valid) begin
            hist[0] <= s3.sum;
            for (int k = 1; k < WIN; k++) begin
                hist[k] <= hist[k-1];
            end
        end
    end

    // ####################
    // Row accumulator
    // ####################

    assign s3_col = s3.pos.col[COL_W-1:0];

    // Load at the row start, grow for the first WIN columns, then slide
    always_comb begin
        if (s3_col == '0) begin
            acc_next = winsum_t'(s3.sum);
        end else if (s3_col < COL_W'(WIN)) begin
            acc_next = acc_q + winsum_t'(s3.sum);
        end else begin
            acc_next = acc_q + winsum_t'(s3.sum) - winsum_t'(hist[WIN-1]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
            o_pos <= '0;
        end else if (s3_valid) begin
            acc_q <= acc_next;
            o_pos <= s3.pos;  // Bottom-right corner of the window
        end
    end

    assign o_sum = acc_q;

endmodule

// File: source/line_buffer.sv
`timescale 1ns/100ps

module line_buffer #(
    parameter int COLS = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    input  pixel_pkg::pixel_t       i_pixel,
    input  raster_pkg::raster_pos_t i_pos,
    output logic                    o_valid,
    output pixel_pkg::column_t      o_column,
    output raster_pkg::raster_pos_t o_pos
);
    import pixel_pkg::*;
    import raster_pkg::*;

    localparam int LINES  = WIN - 1;
    localparam int ADDR_W = $clog2(COLS);

    // line_mem[0] holds the row above, line_mem[LINES-1] the oldest
    pixel_t            line_mem [LINES][COLS];
    pixel_t            tap      [LINES];
    logic [ADDR_W-1:0] addr;
    column_t           column_next;

    assign addr = i_pos.col[ADDR_W-1:0];

    // ####################
    // Line memories
    // ####################

    always_comb begin
        for (int k = 0; k < LINES; k++) begin
            tap[k] = line_mem[k][addr];
        end
    end

    // Shift the column down one line, newest pixel goes on top
    always_ff @(posedge clk) begin
        if (i_valid) begin
            line_mem[0][addr] <= i_pixel;
            for (int k = 1; k < LINES; k++) begin
                line_mem[k][addr] <= tap[k-1];
            end
        end
    end

    // ####################
    // Column assembly
    // ####################

    // Older lines may still hold the previous frame, so mask by row
    always_comb begin
        column_next.cur = i_pixel;
        column_next.up1 = (i_pos.row > POS_W'(0)) ? tap[0] : '0;
        column_next.up2 = (i_pos.row > POS_W'(1)) ? tap[1] : '0;
        column_next.up3 = (i_pos.row > POS_W'(2)) ? tap[2] : '0;
        column_next.top = (i_pos.row > POS_W'(3)) ? tap[3] : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid  <= 1'b0;
            o_column <= '0;
            o_pos    <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_column <= column_next;
                o_pos    <= i_pos;
            end
        end
    end

endmodule

// File: source/raster_counter.sv
`timescale 1ns/100ps

module raster_counter #(
    parameter int COLS = 16,
    parameter int ROWS = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_valid,
    output raster_pkg::raster_pos_t o_pos
);
    import raster_pkg::*;

    logic [POS_W-1:0] col_q;
    logic [POS_W-1:0] row_q;
    logic             last_col;
    logic             last_row;

    // ####################
    // Frame edges
    // ####################

    assign last_col = (col_q == POS_W'(COLS - 1));
    assign last_row = (row_q == POS_W'(ROWS - 1));

    // ####################
    // Counters
    // ####################

    // Steps once per accepted pixel, next frame starts right after the last one
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
            row_q <= '0;
        end else if (i_valid) begin
            if (last_col) begin
                col_q <= '0;
                if (last_row) begin
                    row_q <= '0;  // Wrap to a new frame
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // Position of the pixel presented in this cycle
    assign o_pos.row = row_q;
    assign o_pos.col = col_q;

endmodule

// File: source/raster_pkg.sv
package raster_pkg;

    // ####################
    // Raster position
    // ####################

    localparam int POS_W = 10;  // Frames up to 1024 x 1024

    // Position of one pixel inside the frame
    typedef struct packed {
        logic [POS_W-1:0] row;
        logic [POS_W-1:0] col;
    } raster_pos_t;

endpackage

// File: source/pixel_pkg.sv
package pixel_pkg;

    // ####################
    // Pixel and window sizes
    // ####################

    localparam int PIX_W    = 8;   // Greyscale depth
    localparam int WIN      = 5;   // Window is WIN x WIN
    localparam int COLSUM_W = 11;  // Holds 5 * 255
    localparam int SUM_W    = 13;  // Holds 25 * 255

    typedef logic [PIX_W-1:0] pixel_t;

    // One vertical slice of the window, cur is the newest row
    typedef struct packed {
        pixel_t top;
        pixel_t up3;
        pixel_t up2;
        pixel_t up1;
        pixel_t cur;
    } column_t;

    typedef logic [COLSUM_W-1:0] colsum_t;
    typedef logic [SUM_W-1:0]    winsum_t;

endpackage
